// File: list.f
verilog/bar_graph_pkg.sv
verilog/sample_fifo.sv
verilog/bar_sequencer.sv
verilog/lcd_bus_writer.sv
verilog/bar_graph_top.sv
sim/bar_graph_tb.sv

// File: Bender.yml
package:
  name: bar_graph

sources:
  # Design, in compile order.
  - verilog/bar_graph_pkg.sv
  - verilog/sample_fifo.sv
  - verilog/bar_sequencer.sv
  - verilog/lcd_bus_writer.sv
  - verilog/bar_graph_top.sv

  # Testbench.
  - target: simulation
    files:
      - sim/bar_graph_tb.sv

// File: sim/bar_graph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bar_graph_tb import bar_graph_pkg::*; ();

	////////////////////////////////////////
	// DUT signals.
	////////////////////////////////////////
	logic      clk_20MHz;
	logic      rst_n;
	logic      sample_valid;
	count_t    sample_count;
	logic      credit_return;
	logic      lcd_cs;
	logic      lcd_rs;
	logic      lcd_wr;
	bus_word_t lcd_data;

	// Scoreboard state.
	int errors         = 0;
	int checks         = 0;
	int tests_run      = 0;
	int sent_total     = 0;     // Counts handed to the DUT.
	int returned_total = 0;     // Credit pulses seen.
	int checked_total  = 0;     // Bars compared.
	int wraps_seen     = 0;     // ROW_LAST followed by ROW_FIRST.
	int test_cycles    = 0;
	int test_limit     = 1000;  // Covers reset and the first idle check.
	int test_err0      = 0;
	string test_name   = "reset";

	count_t      sent_q[$];     // Sent counts, oldest first.
	logic [16:0] got_words[$];  // {rs, data} per strobe.
	int          bar_lens[$];   // Words per finished bar.
	int          cur_len  = 0;
	logic        prev_wr  = 1'b1;
	logic        prev_cs  = 1'b1;
	coord_t      exp_row  = ROW_FIRST;
	coord_t      last_row = '0;

	bar_graph_top dut0 (
		.clk_20MHz     (clk_20MHz),
		.rst_n         (rst_n),
		.sample_valid  (sample_valid),
		.sample_count  (sample_count),
		.credit_return (credit_return),
		.lcd_cs        (lcd_cs),
		.lcd_rs        (lcd_rs),
		.lcd_wr        (lcd_wr),
		.lcd_data      (lcd_data)
	);

	initial begin
		clk_20MHz = 1'b0;
		forever #25 clk_20MHz = ~clk_20MHz;  // 50 ns period.
	end

	////////////////////////////////////////
	// Reference model.
	////////////////////////////////////////
	// Seven command words, then count+1 pixels.
	function automatic int bar_word_count(count_t c);
		return int'(c) + 8;
	endfunction

	// Expected {rs, data} of word idx of one bar.
	function automatic logic [16:0] expected_word(count_t c, coord_t row, int idx);
		coord_t x_end;
		x_end = BAR_X_OFFSET + coord_t'(c);  // Length follows count.
		case (idx)
			0:       return {1'b0, OP_COL_ADDR};
			1:       return {1'b1, bus_word_t'(BAR_X_OFFSET)};
			2:       return {1'b1, bus_word_t'(x_end)};
			3:       return {1'b0, OP_ROW_ADDR};
			4, 5:    return {1'b1, bus_word_t'(row)};  // Row window, start equals end.
			6:       return {1'b0, OP_MEM_WRITE};
			default: return {1'b1, BAR_COLOR};
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Monitors.
	////////////////////////////////////////
	// Bus sampled mid-cycle, away from the clock edge.
	always @(negedge clk_20MHz) begin
		if (!rst_n) begin
			prev_wr = 1'b1;
			prev_cs = 1'b1;
			cur_len = 0;
		end else begin
			if (!prev_wr && lcd_wr) begin
				got_words.push_back({lcd_rs, lcd_data});  // Word taken on rising strobe.
				cur_len++;
			end
			if (!prev_cs && lcd_cs) begin
				bar_lens.push_back(cur_len);  // Bar ends with chip select.
				cur_len = 0;
			end
			prev_wr = lcd_wr;
			prev_cs = lcd_cs;
		end
	end

	always @(posedge clk_20MHz) begin
		if (rst_n && credit_return) begin
			returned_total++;
			if (returned_total > sent_total) begin
				errors++;
				$display("Credit returned at %0t with no count outstanding", $time);
			end
		end
	end

	// Compare each finished bar with the oldest sent count.
	always @(posedge clk_20MHz) begin : compare_bars
		int          len;
		count_t      c;
		logic [16:0] w;
		coord_t      row_seen;
		if (bar_lens.size() > 0) begin
			len = bar_lens.pop_front();
			if (sent_q.size() == 0) begin
				errors++;
				$display("Bar on the LCD bus at %0t with no count outstanding", $time);
				for (int i = 0; i < len; i++) w = got_words.pop_front();
			end else begin
				c = sent_q.pop_front();
				check($sformatf("bar %0d length", checked_total), len, bar_word_count(c));
				row_seen = '0;
				for (int i = 0; i < len; i++) begin
					w = got_words.pop_front();
					if (i == 4) row_seen = coord_t'(w[15:0]);
					if (i < bar_word_count(c)) begin
						check($sformatf("bar %0d word %0d {lcd_rs,lcd_data}", checked_total, i),
							w, expected_word(c, exp_row, i));
					end
				end
				if (last_row == ROW_LAST && row_seen == ROW_FIRST) wraps_seen++;
				last_row = row_seen;
				exp_row  = (exp_row == ROW_LAST) ? ROW_FIRST : exp_row + 1'b1;  // Next row.
				checked_total++;
			end
		end
	end

	// Per-test watchdog.
	always @(posedge clk_20MHz) begin
		test_cycles++;
		if (test_cycles > test_limit) begin
			$display("Timeout: test %0d (%s) still running after %0d cycles",
				tests_run + 1, test_name, test_cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus tasks.
	////////////////////////////////////////
	task automatic start_test(input string name);
		test_name   = name;
		test_err0   = errors;
		test_cycles = 0;
		test_limit  = 1000;  // Grows with every count sent.
	endtask

	task automatic end_test();
		tests_run++;
		$display("Test %0d %s finished with %0d errors", tests_run, test_name, errors - test_err0);
	endtask

	// One count per cycle while credits last.
	task automatic send_count(input count_t c);
		while (FIFO_DEPTH - (sent_total - returned_total) <= 0) @(negedge clk_20MHz);
		sample_valid = 1'b1;
		sample_count = c;
		sent_q.push_back(c);
		sent_total++;
		test_limit += 2 * (int'(c) + 10);  // Bar length plus handoff.
		@(negedge clk_20MHz);
		sample_valid = 1'b0;
	endtask

	task automatic drain();
		while (checked_total < sent_total) @(negedge clk_20MHz);
		repeat (8) @(negedge clk_20MHz);  // Bus should stay idle.
		check("lcd_cs", lcd_cs, 1'b1);
		check("stray lcd_wr words", got_words.size(), 0);
	endtask

	////////////////////////////////////////
	// Test sequence.
	////////////////////////////////////////
	initial begin : main
		int seed_val;
		int wraps_before;
		rst_n        = 1'b0;
		sample_valid = 1'b0;
		sample_count = '0;
		seed_val     = $urandom(32'he3f376b5);  // Seed once.
		repeat (16) @(negedge clk_20MHz);
		rst_n = 1'b1;

		start_test("after reset");
		check("lcd_cs", lcd_cs, 1'b1);
		check("lcd_wr", lcd_wr, 1'b1);
		check("lcd_rs", lcd_rs, 1'b1);
		check("lcd_data", lcd_data, '0);
		repeat (20) @(negedge clk_20MHz);
		check("credit_return pulses", returned_total, 0);
		end_test();

		start_test("single count 5");
		send_count(8'd5);
		drain();
		check("credit_return pulses", returned_total, 1);
		end_test();

		start_test("edge counts 0 and 255");
		send_count(8'd0);
		send_count(8'd255);
		drain();
		end_test();

		start_test("burst of 16");
		for (int i = 0; i < 16; i++) send_count(count_t'($urandom));
		drain();
		check("credit_return pulses", returned_total, sent_total);
		end_test();

		start_test("back-pressure 200");
		for (int i = 0; i < 200; i++) send_count(count_t'($urandom));
		drain();
		check("source credits", FIFO_DEPTH - (sent_total - returned_total), FIFO_DEPTH);
		end_test();

		start_test("row wrap");
		wraps_before = wraps_seen;
		for (int i = 0; i < 700; i++) send_count(8'd0);
		drain();
		check("row wraps", wraps_seen - wraps_before, 1);
		end_test();

		$display("Summary: %0d tests, %0d bars, %0d checks, %0d errors",
			tests_run, checked_total, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule : bar_graph_tb

`default_nettype wire

// File: verilog/bar_graph_top.sv
`timescale 1ns/1ps
`default_nettype none

module bar_graph_top import bar_graph_pkg::*; (
	input  wire logic   clk_20MHz,
	input  wire logic   rst_n,
	input  wire logic   sample_valid,   // Credit-based count input.
	input  wire count_t sample_count,
	output logic        credit_return,  // One credit back per pulse.
	output logic        lcd_cs,
	output logic        lcd_rs,
	output logic        lcd_wr,
	output bus_word_t   lcd_data
);

	////////////////////////////////////////
	// Internal nets.
	////////////////////////////////////////
	count_t fifo_count;     // FIFO head.
	logic   fifo_nonempty;
	logic   fifo_pop;
	logic   line_valid;     // Sequencer to writer.
	coord_t line_x_end;
	coord_t line_row;
	logic   line_done;      // Writer credit return.

	// Input side.
	sample_fifo u_fifo (
		.clk_20MHz     (clk_20MHz),
		.rst_n         (rst_n),
		.sample_valid  (sample_valid),
		.sample_count  (sample_count),
		.fifo_pop      (fifo_pop),
		.fifo_count    (fifo_count),
		.fifo_nonempty (fifo_nonempty),
		.credit_return (credit_return)
	);

	// Counts to line commands.
	bar_sequencer u_seq (
		.clk_20MHz     (clk_20MHz),
		.rst_n         (rst_n),
		.fifo_count    (fifo_count),
		.fifo_nonempty (fifo_nonempty),
		.line_done     (line_done),
		.fifo_pop      (fifo_pop),
		.line_valid    (line_valid),
		.line_x_end    (line_x_end),
		.line_row      (line_row)
	);

	// TFT bus side.
	lcd_bus_writer u_lcd (
		.clk_20MHz  (clk_20MHz),
		.rst_n      (rst_n),
		.line_valid (line_valid),
		.line_x_end (line_x_end),
		.line_row   (line_row),
		.line_done  (line_done),
		.lcd_cs     (lcd_cs),
		.lcd_rs     (lcd_rs),
		.lcd_wr     (lcd_wr),
		.lcd_data   (lcd_data)
	);

endmodule : bar_graph_top

`default_nettype wire

// File: verilog/lcd_bus_writer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_writer import bar_graph_pkg::*; (
	input  wire logic   clk_20MHz,
	input  wire logic   rst_n,
	input  wire logic   line_valid,   // New line command.
	input  wire coord_t line_x_end,
	input  wire coord_t line_row,
	output logic        line_done,    // Pulse after last pixel word.
	output logic        lcd_cs,
	output logic        lcd_rs,       // 0 opcode, 1 data.
	output logic        lcd_wr,       // Word taken on rising edge.
	output bus_word_t   lcd_data
);

	////////////////////////////////////////
	// Word sequence of one command.
	////////////////////////////////////////
	typedef enum logic [2:0] {
		ST_COL_OP,     // Column window opcode.
		ST_COL_START,  // Left column.
		ST_COL_END,    // Right column.
		ST_ROW_OP,     // Row window opcode.
		ST_ROW_START,  // Row, first copy.
		ST_ROW_END,    // Row, second copy.
		ST_MEM_OP,     // Memory write opcode.
		ST_PIXEL       // Colour words.
	} step_t;

	logic   busy;      // Command on the bus.
	logic   half;      // 0 strobe low, 1 strobe high.
	step_t  step;
	coord_t pix_left;  // Pixels still to go after the current one.
	coord_t x_end_q;   // Latched command.
	coord_t row_q;

	// Bus word for a given step.
	function automatic bus_word_t word_data(step_t st, coord_t x_end, coord_t row);
		bus_word_t w;
		case (st)
			ST_COL_OP:    w = OP_COL_ADDR;
			ST_COL_START: w = bus_word_t'(BAR_X_OFFSET);
			ST_COL_END:   w = bus_word_t'(x_end);
			ST_ROW_OP:    w = OP_ROW_ADDR;
			ST_ROW_START: w = bus_word_t'(row);
			ST_ROW_END:   w = bus_word_t'(row);
			ST_MEM_OP:    w = OP_MEM_WRITE;
			default:      w = BAR_COLOR;
		endcase
		return w;
	endfunction

	// RS level for a given step.
	function automatic logic word_is_data(step_t st);
		return !(st == ST_COL_OP || st == ST_ROW_OP || st == ST_MEM_OP);
	endfunction

	////////////////////////////////////////
	// Command latch.
	////////////////////////////////////////
	always_ff @(posedge clk_20MHz) begin
		if (line_valid && !busy) begin
			x_end_q <= line_x_end;
			row_q   <= line_row;
		end
	end

	////////////////////////////////////////
	// Bus sequencer.
	////////////////////////////////////////
	always_ff @(posedge clk_20MHz or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			half      <= 1'b0;
			step      <= ST_COL_OP;
			pix_left  <= '0;
			line_done <= 1'b0;
			lcd_cs    <= 1'b1;
			lcd_wr    <= 1'b1;
			lcd_rs    <= 1'b1;
			lcd_data  <= '0;
		end else begin
			line_done <= 1'b0;  // Single-cycle pulse.
			if (!busy) begin
				if (line_valid) begin
					busy     <= 1'b1;
					half     <= 1'b0;
					step     <= ST_COL_OP;
					pix_left <= line_x_end - BAR_X_OFFSET;  // Pixels minus one.
					lcd_cs   <= 1'b0;                       // Select for whole command.
					lcd_wr   <= 1'b0;
					lcd_rs   <= word_is_data(ST_COL_OP);
					lcd_data <= word_data(ST_COL_OP, line_x_end, line_row);
				end
			end else if (!half) begin
				lcd_wr <= 1'b1;  // Rising edge latches word.
				half   <= 1'b1;
			end else begin
				half <= 1'b0;
				if (step == ST_PIXEL && pix_left == '0) begin
					// Last pixel done.
					busy      <= 1'b0;
					lcd_cs    <= 1'b1;
					lcd_rs    <= 1'b1;
					line_done <= 1'b1;
				end else if (step == ST_PIXEL) begin
					pix_left <= pix_left - 1'b1;  // Another colour word.
					lcd_wr   <= 1'b0;
				end else begin
					step     <= step_t'(step + 3'd1);
					lcd_wr   <= 1'b0;
					lcd_rs   <= word_is_data(step_t'(step + 3'd1));
					lcd_data <= word_data(step_t'(step + 3'd1), x_end_q, row_q);
				end
			end
		end
	end

	////////////////////////////////////////
	// Checks.
	////////////////////////////////////////
	// The sequencer credit must keep commands apart.
	a_no_overlap: assert property (@(posedge clk_20MHz) disable iff (!rst_n)
		line_valid |-> !busy)
		else $error("lcd_bus_writer: line_valid during a command");

endmodule : lcd_bus_writer

`default_nettype wire

// File: verilog/bar_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bar_sequencer import bar_graph_pkg::*; (
	input  wire logic   clk_20MHz,
	input  wire logic   rst_n,
	input  wire count_t fifo_count,     // Head of sample FIFO.
	input  wire logic   fifo_nonempty,
	input  wire logic   line_done,      // Writer finished, credit back.
	output logic        fifo_pop,
	output logic        line_valid,     // One-cycle line command.
	output coord_t      line_x_end,
	output coord_t      line_row
);

	////////////////////////////////////////
	// Credit toward the bus writer.
	////////////////////////////////////////
	logic have_credit;  // Single credit, writer is free.
	coord_t row;        // Row of the next bar.

	// Pop as soon as a count waits and the writer is free.
	assign fifo_pop = have_credit & fifo_nonempty;

	always_ff @(posedge clk_20MHz or negedge rst_n) begin
		if (!rst_n) begin
			have_credit <= 1'b1;  // Writer idle after reset.
		end else if (fifo_pop) begin
			have_credit <= 1'b0;  // Spent on this count.
		end else if (line_done) begin
			have_credit <= 1'b1;  // Returned by writer.
		end
	end

	////////////////////////////////////////
	// Line command.
	////////////////////////////////////////
	always_ff @(posedge clk_20MHz or negedge rst_n) begin
		if (!rst_n) begin
			line_valid <= 1'b0;
		end else begin
			line_valid <= fifo_pop;  // Issue one cycle after pop.
		end
	end

	// End column, payload only.
	always_ff @(posedge clk_20MHz) begin
		if (fifo_pop) begin
			line_x_end <= BAR_X_OFFSET + coord_t'(fifo_count);  // Length follows count.
		end
	end

	////////////////////////////////////////
	// Row tracking.
	////////////////////////////////////////
	always_ff @(posedge clk_20MHz or negedge rst_n) begin
		if (!rst_n) begin
			row <= ROW_FIRST;
		end else if (line_valid) begin
			// Next bar one row down.
			if (row == ROW_LAST) begin
				row <= ROW_FIRST;  // Wrap to top.
			end else begin
				row <= row + 1'b1;
			end
		end
	end

	assign line_row = row;  // Held steady during the issue cycle.

	////////////////////////////////////////
	// Checks.
	////////////////////////////////////////
	// A spurious line_done would let line_valid go out without a credit.
	a_valid_needs_credit: assert property (@(posedge clk_20MHz) disable iff (!rst_n)
		line_done |-> !have_credit)
		else $error("bar_sequencer: line_done while credit held");

endmodule : bar_sequencer

`default_nettype wire

// File: verilog/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import bar_graph_pkg::*; (
	input  wire logic   clk_20MHz,
	input  wire logic   rst_n,
	input  wire logic   sample_valid,   // One count per pulse, credit spent.
	input  wire count_t sample_count,
	input  wire logic   fifo_pop,       // Drop head entry.
	output count_t      fifo_count,     // Head entry, valid when nonempty.
	output logic        fifo_nonempty,
	output logic        credit_return   // One pulse per popped entry.
);

	////////////////////////////////////////
	// Storage and pointers.
	////////////////////////////////////////
	count_t mem [FIFO_DEPTH];                   // Circular buffer.
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;      // Next free slot.
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;      // Head slot.
	logic [CREDIT_W-1:0] occupancy;             // Entries held.

	// Entry data, no reset needed.
	always_ff @(posedge clk_20MHz) begin
		if (sample_valid) begin
			mem[wr_ptr] <= sample_count;  // Store count.
		end
	end

	always_ff @(posedge clk_20MHz or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			occupancy     <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= fifo_pop;  // Credit goes back a cycle after pop.
			if (sample_valid) begin
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth.
			end
			if (fifo_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({sample_valid, fifo_pop})
				2'b10:   occupancy <= occupancy + 1'b1;  // Push only.
				2'b01:   occupancy <= occupancy - 1'b1;  // Pop only.
				default: occupancy <= occupancy;         // Both or none.
			endcase
		end
	end

	assign fifo_count    = mem[rd_ptr];         // Show-ahead head.
	assign fifo_nonempty = (occupancy != '0);

	////////////////////////////////////////
	// Protocol checks.
	////////////////////////////////////////
	// Upstream overran its credits.
	a_no_write_when_full: assert property (@(posedge clk_20MHz) disable iff (!rst_n)
		sample_valid |-> (occupancy != CREDIT_W'(FIFO_DEPTH)))
		else $error("sample_fifo: write while full, credit violation");

	// Sequencer popped nothing.
	a_no_pop_when_empty: assert property (@(posedge clk_20MHz) disable iff (!rst_n)
		fifo_pop |-> fifo_nonempty)
		else $error("sample_fifo: pop while empty");

endmodule : sample_fifo

`default_nettype wire

// File: verilog/bar_graph_pkg.sv
`default_nettype none

package bar_graph_pkg;

	////////////////////////////////////////
	// Widths.
	////////////////////////////////////////
	localparam int COUNT_W    = 8;   // Pulse count from upstream.
	localparam int COORD_W    = 10;  // Screen x or y.
	localparam int BUS_W      = 16;  // TFT data bus.
	localparam int FIFO_DEPTH = 16;  // Also the upstream credit budget.
	localparam int CREDIT_W   = 5;   // Holds 0..FIFO_DEPTH.

	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [BUS_W-1:0]   bus_word_t;

	////////////////////////////////////////
	// Screen geometry of the bar graph.
	////////////////////////////////////////
	localparam coord_t BAR_X_OFFSET = 10'd10;   // Left edge of every bar.
	localparam coord_t ROW_FIRST    = 10'd10;   // Top bar row.
	localparam coord_t ROW_LAST     = 10'd698;  // Wrap point.

	// RGB565 red.
	localparam bus_word_t BAR_COLOR = 16'hF800;

	////////////////////////////////////////
	// TFT command opcodes.
	////////////////////////////////////////
	localparam bus_word_t OP_COL_ADDR  = 16'h002A;  // Column window.
	localparam bus_word_t OP_ROW_ADDR  = 16'h002B;  // Row window.
	localparam bus_word_t OP_MEM_WRITE = 16'h002C;  // Start of pixel data.

endpackage : bar_graph_pkg

`default_nettype wire
